// ==== list.f ====
+incdir+src
src/mult_data_pkg.sv
src/mult_ctrl_pkg.sv
src/partial_product_unit.sv
src/product_merge.sv
src/multiplier_32x32.sv
verification/multiplier_32x32_chk.sv
verification/multiplier_32x32_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the multiplier testbench with Verilator.
# Exits non-zero when the build fails, the simulation fails,
# or the log shows the fail message.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_multiplier
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f list.f \
   --top-module multiplier_32x32_tb \
   -Mdir "$BUILD_DIR" \
   -o "$SIM_BIN"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Testbench failed" "$LOG_FILE"; then
   echo "Failure reported in $LOG_FILE"
   exit 1
fi

if ! grep -q "Testbench passed" "$LOG_FILE"; then
   echo "No pass message found in $LOG_FILE"
   exit 1
fi

exit 0

// ==== src/mult_ctrl_pkg.sv ====
// Control types of the multiplier
// Operation select encoding and the state of the output register

package mult_ctrl_pkg;

   // ------------------------------------------------------------
   // Operation select
   // ------------------------------------------------------------

   // Encoding follows the op_sel port
   // MUL keeps the low word, the others keep the high word
   typedef enum logic [1:0] {
      // Low word, signedness does not matter
      OP_MUL    = 2'd0,
      // High word, signed x signed
      OP_MULH   = 2'd1,
      // High word, signed a x unsigned b
      OP_MULHSU = 2'd2,
      // High word, unsigned x unsigned
      OP_MULHU  = 2'd3
   } mult_op_e;

   // ------------------------------------------------------------
   // Output register state
   // ------------------------------------------------------------

   // FULL means result is valid and waits for out_ready
   typedef enum logic {
      OUT_EMPTY = 1'b0,
      OUT_FULL  = 1'b1
   } out_state_e;

endpackage

// ==== src/mult_data_pkg.sv ====
// Data types of the multiplier datapath
// Operand words, signed partial products and the full double-width product

`include "mult_macros.svh"

package mult_data_pkg;

   // ------------------------------------------------------------
   // Operand and result words
   // ------------------------------------------------------------

   // Operands a, b and the selected result half
   typedef logic [`MULT_W-1:0] operand_t;

   // ------------------------------------------------------------
   // Products
   // ------------------------------------------------------------

   // One partial product, always signed after operand extension
   typedef logic signed [`PART_W-1:0] partial_t;

   // Full product after the merge, low and high words together
   typedef logic [2*`MULT_W-1:0] product_t;

endpackage

// ==== src/mult_macros.svh ====
// Width definitions for the pipelined 32x32 multiplier
// Operand width, b slice width and partial product width
// Partial product holds a 33-bit extended a times a 17-bit extended slice

`ifndef MULT_MACROS_SVH
`define MULT_MACROS_SVH

// Operand and result width, one word
`define MULT_W 32

// Width of one slice of b
`define HALF_W 16

// Extended a (MULT_W+1) times extended slice (HALF_W+1)
`define PART_W (`MULT_W + `HALF_W + 2)

`endif

// ==== src/multiplier_32x32.sv ====
// Pipelined 32x32 integer multiplier, top level
// Two partial product units split b into 16-bit slices,
// the merge stage adds them and returns the low or high word.
// Two register stages, valid/ready on input and output

`include "mult_macros.svh"

module multiplier_32x32
   import mult_data_pkg::*;
   import mult_ctrl_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   // Operation input
   input  operand_t   a,
   input  operand_t   b,
   input  logic [1:0] op_sel,
   input  logic       in_valid,
   output logic       in_ready,
   // Result output
   output logic       out_valid,
   input  logic       out_ready,
   output operand_t   result
);

   // Stage 1 partial products
   partial_t part_lo;
   partial_t part_hi;

   // Shared pipeline enable
   logic advance;

   // ------------------------------------------------------------
   // Stage 1, partial products
   // ------------------------------------------------------------

   // a x b[15:0]
   partial_product_unit #(
      .HIGH_SLICE (1'b0)
   ) pp_lo_i (
      .clk     (clk),
      .rst     (rst),
      .advance (advance),
      .a       (a),
      .b       (b),
      .op_sel  (mult_op_e'(op_sel)),
      .part    (part_lo)
   );

   // a x b[31:16]
   partial_product_unit #(
      .HIGH_SLICE (1'b1)
   ) pp_hi_i (
      .clk     (clk),
      .rst     (rst),
      .advance (advance),
      .a       (a),
      .b       (b),
      .op_sel  (mult_op_e'(op_sel)),
      .part    (part_hi)
   );

   // ------------------------------------------------------------
   // Stage 2, merge and output handshake
   // ------------------------------------------------------------

   product_merge merge_i (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .op_sel    (mult_op_e'(op_sel)),
      .part_lo   (part_lo),
      .part_hi   (part_hi),
      .out_ready (out_ready),
      .advance   (advance),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .result    (result)
   );

endmodule

// ==== src/partial_product_unit.sv ====
// Partial product unit of the 32x32 multiplier
// Multiplies a by one 16-bit slice of b, with operand extension
// chosen from the operation, and registers the signed product
// HIGH_SLICE selects b[15:0] (0) or b[31:16] (1)

`include "mult_macros.svh"

module partial_product_unit
   import mult_data_pkg::*;
   import mult_ctrl_pkg::*;
#(
   parameter bit HIGH_SLICE = 1'b0
) (
   input  logic     clk,
   input  logic     rst,
   // Pipeline enable from the merge stage
   input  logic     advance,
   input  operand_t a,
   input  operand_t b,
   input  mult_op_e op_sel,
   // Registered partial product
   output partial_t part
);

   // Slice of b handled by this unit
   logic [`HALF_W-1:0] b_slice;

   // Sign control for each operand
   logic a_signed;
   logic b_signed;

   // Operands extended by one bit, then multiplied as signed numbers
   logic signed [`MULT_W:0] a_ext;
   logic signed [`HALF_W:0] b_ext;
   partial_t                prod;

   // ------------------------------------------------------------
   // Operand extension
   // ------------------------------------------------------------

   always_comb begin
      // Pick the slice of b
      if (HIGH_SLICE) begin
         b_slice = b[2*`HALF_W-1:`HALF_W];
      end else begin
         b_slice = b[`HALF_W-1:0];
      end

      // a is signed for MULH and MULHSU
      a_signed = (op_sel == OP_MULH) || (op_sel == OP_MULHSU);
      // Low slice never carries the sign of b
      b_signed = HIGH_SLICE && (op_sel == OP_MULH);

      a_ext = {a_signed & a[`MULT_W-1], a};
      b_ext = {b_signed & b_slice[`HALF_W-1], b_slice};

      // 33 x 17 bits fits exactly in PART_W
      prod = a_ext * b_ext;
   end

   // ------------------------------------------------------------
   // Stage 1 register
   // ------------------------------------------------------------

   // Holds while the pipeline is stalled
   always_ff @(posedge clk) begin
      if (rst) begin
         part <= '0;
      end else if (advance) begin
         part <= prod;
      end
   end

endmodule

// ==== src/product_merge.sv ====
// Merge stage of the 32x32 multiplier
// Adds the two partial products into the full 64-bit product,
// keeps the low or high word and holds it in the output register.
// Also owns the stage 1 control bits, the stall signal and
// the output valid/ready handshake

`include "mult_macros.svh"

module product_merge
   import mult_data_pkg::*;
   import mult_ctrl_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   // Input side handshake and operation
   input  logic     in_valid,
   input  mult_op_e op_sel,
   // Registered partial products from stage 1
   input  partial_t part_lo,
   input  partial_t part_hi,
   // Output side handshake
   input  logic     out_ready,
   output logic     advance,
   output logic     in_ready,
   output logic     out_valid,
   output operand_t result
);

   // Stage 1 control, aligned with the partial product registers
   logic     s1_valid;
   mult_op_e s1_op;

   // Output register state
   out_state_e state;
   out_state_e state_next;

   // Merge datapath
   product_t lo_ext;
   product_t hi_ext;
   product_t full_prod;
   operand_t result_next;

   // ------------------------------------------------------------
   // Flow control
   // ------------------------------------------------------------

   // Move when the output slot is free or is being drained now
   assign advance   = (state == OUT_EMPTY) || out_ready;
   // Whole pipeline shares one enable
   assign in_ready  = advance;
   assign out_valid = (state == OUT_FULL);

   // ------------------------------------------------------------
   // Stage 1 control registers
   // ------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         s1_valid <= 1'b0;
         s1_op    <= OP_MUL;
      end else if (advance) begin
         // in_valid taken only when in_ready is high
         s1_valid <= in_valid;
         s1_op    <= op_sel;
      end
   end

   // ------------------------------------------------------------
   // Merge datapath
   // ------------------------------------------------------------

   always_comb begin
      // Sign-extend both partials to the full product width
      lo_ext = {{(2*`MULT_W-`PART_W){part_lo[`PART_W-1]}}, part_lo};
      hi_ext = {{(2*`MULT_W-`PART_W){part_hi[`PART_W-1]}}, part_hi};

      // High slice weighs 2^16; wrap at 64 bits gives the right product
      full_prod = lo_ext + (hi_ext << `HALF_W);

      // MUL keeps the low word, all other ops the high word
      if (s1_op == OP_MUL) begin
         result_next = full_prod[`MULT_W-1:0];
      end else begin
         result_next = full_prod[2*`MULT_W-1:`MULT_W];
      end
   end

   // ------------------------------------------------------------
   // Output register and its state machine
   // ------------------------------------------------------------

   always_comb begin
      state_next = state;
      case (state)
         OUT_EMPTY: begin
            if (s1_valid) begin
               state_next = OUT_FULL;
            end
         end
         OUT_FULL: begin
            // Taken with nothing behind it
            if (out_ready && !s1_valid) begin
               state_next = OUT_EMPTY;
            end
         end
         default: state_next = OUT_EMPTY;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= OUT_EMPTY;
      end else begin
         state <= state_next;
      end
   end

   // Result payload, loaded only with a valid stage 1 entry
   always_ff @(posedge clk) begin
      if (advance && s1_valid) begin
         result <= result_next;
      end
   end

endmodule

// ==== verification/multiplier_32x32_chk.sv ====
// Handshake and reset assertions for the 32x32 multiplier
// Bound into every multiplier_32x32 instance

`include "mult_macros.svh"

module multiplier_32x32_chk (
   input logic               clk,
   input logic               rst,
   input logic               in_ready,
   input logic               out_valid,
   input logic               out_ready,
   input logic [`MULT_W-1:0] result
);

   // ------------------------------------------------------------
   // Reset
   // ------------------------------------------------------------

   // Output register comes out of reset empty
   reset_clears_valid: assert property (
      @(posedge clk) rst |=> !out_valid
   ) else $error("out_valid high in the cycle after reset");

   // ------------------------------------------------------------
   // Output stall
   // ------------------------------------------------------------

   // A result that is not taken stays in place, unchanged
   stall_holds_result: assert property (
      @(posedge clk) disable iff (rst)
      (out_valid && !out_ready) |=> (out_valid && $stable(result))
   ) else $error("result or out_valid changed during a stall");

   // ------------------------------------------------------------
   // Input side
   // ------------------------------------------------------------

   // Input accepted unless the output slot is full and blocked
   ready_matches_stall: assert property (
      @(posedge clk) disable iff (rst)
      in_ready == !(out_valid && !out_ready)
   ) else $error("in_ready does not follow the output stall");

endmodule

bind multiplier_32x32 multiplier_32x32_chk chk_i (
   .clk       (clk),
   .rst       (rst),
   .in_ready  (in_ready),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .result    (result)
);

// ==== verification/multiplier_32x32_tb.sv ====
// Testbench for the pipelined 32x32 multiplier
// Random operations from a fixed seed, a reference model and a
// scoreboard queue kept in order of acceptance, with a cycle timeout

`include "mult_macros.svh"

module multiplier_32x32_tb
   import mult_ctrl_pkg::*;
();

   // Transactions in each of the four tests that send operations
   localparam int unsigned NUM_TXN        = 200;
   localparam int unsigned TIMEOUT_CYCLES = 4 * NUM_TXN * 10 + 200;
   localparam int unsigned DRAIN_LIMIT    = 100;

   // Operand and op selection modes
   localparam int MIX_RANDOM = 0;
   localparam int MIX_CORNER = 1;
   localparam int MIX_ONES   = 2;
   localparam int OPS_MUL    = 0;
   localparam int OPS_HIGH_S = 1;
   localparam int OPS_MULHU  = 2;
   localparam int OPS_ANY    = 3;

   logic               clk;
   logic               rst;
   logic [`MULT_W-1:0] a;
   logic [`MULT_W-1:0] b;
   logic [1:0]         op_sel;
   logic               in_valid;
   logic               in_ready;
   logic               out_valid;
   logic               out_ready;
   logic [`MULT_W-1:0] result;

   integer      seed = 32'h3de9_841d;
   int unsigned cyc = 0;

   // Scoreboard of expected words and the edge each was accepted on
   logic [`MULT_W-1:0] exp_q[$];
   int unsigned        edge_q[$];
   // Directed operations sent ahead of the random ones
   logic [`MULT_W-1:0] force_a_q[$];
   logic [`MULT_W-1:0] force_b_q[$];
   logic [1:0]         force_op_q[$];

   int operand_mode;
   int op_mode;
   bit ready_random;
   bit check_latency;
   int unsigned accepted;
   int pass_cnt = 0;
   int fail_cnt = 0;
   int test_checks;
   int test_fails;

   multiplier_32x32 multiplier_32x32_i (
      .clk       (clk),
      .rst       (rst),
      .a         (a),
      .b         (b),
      .op_sel    (op_sel),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .result    (result)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   // ------------------------------------------------------------
   // Cycle counter and timeout
   // ------------------------------------------------------------

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= TIMEOUT_CYCLES) begin
         $display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Testbench failed");
         $finish;
      end
   end

   // Reference model widens both operands to 64 bits per op
   function automatic logic [`MULT_W-1:0] model_result(logic [1:0] op,
         logic [`MULT_W-1:0] x, logic [`MULT_W-1:0] y);
      logic [2*`MULT_W-1:0] x_ext;
      logic [2*`MULT_W-1:0] y_ext;
      logic [2*`MULT_W-1:0] prod;
      logic                 x_signed;
      logic                 y_signed;
      x_signed = (op == OP_MULH) || (op == OP_MULHSU);
      y_signed = (op == OP_MULH);
      x_ext = {{`MULT_W{x_signed & x[`MULT_W-1]}}, x};
      y_ext = {{`MULT_W{y_signed & y[`MULT_W-1]}}, y};
      prod  = x_ext * y_ext;
      if (op == OP_MUL) begin
         return prod[`MULT_W-1:0];
      end
      return prod[2*`MULT_W-1:`MULT_W];
   endfunction

   function automatic logic [`MULT_W-1:0] rand_word();
      return $random(seed);
   endfunction

   // About one operand in four is a corner value in the mixed modes
   function automatic logic [`MULT_W-1:0] pick_operand(int mode);
      logic [`MULT_W-1:0] r;
      logic [`MULT_W-1:0] sel;
      r   = rand_word();
      sel = rand_word();
      if (mode == MIX_ONES && sel[1:0] == 2'b00) begin
         r = '1;
      end else if (mode == MIX_CORNER && sel[1:0] == 2'b00) begin
         case (sel[4:2])
            3'd0:    r = 32'h0000_0000;
            3'd1:    r = 32'h0000_0001;
            3'd2:    r = 32'hffff_ffff;
            3'd3:    r = 32'h8000_0000;
            default: r = 32'h7fff_ffff;
         endcase
      end
      return r;
   endfunction

   function automatic logic [1:0] pick_op(int mode);
      logic [`MULT_W-1:0] r;
      r = rand_word();
      case (mode)
         OPS_MUL:    return OP_MUL;
         OPS_HIGH_S: return r[0] ? OP_MULHSU : OP_MULH;
         OPS_MULHU:  return OP_MULHU;
         default:    return r[1:0];
      endcase
   endfunction

   // ------------------------------------------------------------
   // Drive and sample
   // ------------------------------------------------------------

   task automatic drive_inputs(bit allow_new);
      logic [`MULT_W-1:0] r;
      r = rand_word();
      out_ready = ready_random ? r[0] : 1'b1;
      if (!allow_new) begin
         in_valid = 1'b0;
      end else if (force_op_q.size() != 0) begin
         in_valid = 1'b1;
         a        = force_a_q[0];
         b        = force_b_q[0];
         op_sel   = force_op_q[0];
      end else begin
         // 179 of 256 is close to 70 percent
         in_valid = (r[15:8] < 8'd179);
         a        = pick_operand(operand_mode);
         b        = pick_operand(operand_mode);
         op_sel   = pick_op(op_mode);
      end
   endtask

   // Sampled at the falling edge where values hold until the next rising edge
   task automatic sample_handshake();
      logic [`MULT_W-1:0] expected;
      int unsigned        accept_edge;
      if (out_valid && out_ready) begin
         test_checks++;
         if (exp_q.size() == 0) begin
            $display("Output taken at cycle %0d with no operation pending", cyc);
            test_fails++;
         end else begin
            expected    = exp_q.pop_front();
            accept_edge = edge_q.pop_front();
            if (result !== expected) begin
               $display("CHECK FAILED result expected %h actual %h", expected, result);
               test_fails++;
            end
            // The next rising edge takes this result
            if (check_latency && (cyc + 1 - accept_edge != 2)) begin
               $display("Result taken %0d cycles after acceptance, not 2",
                        cyc + 1 - accept_edge);
               test_fails++;
            end
         end
      end
      if (in_valid && in_ready) begin
         exp_q.push_back(model_result(op_sel, a, b));
         edge_q.push_back(cyc + 1);
         accepted++;
         if (force_op_q.size() != 0) begin
            void'(force_a_q.pop_front());
            void'(force_b_q.pop_front());
            void'(force_op_q.pop_front());
         end
      end
   endtask

   task automatic step(bit allow_new);
      @(posedge clk);
      #2;
      drive_inputs(allow_new);
      @(negedge clk);
      sample_handshake();
   endtask

   task automatic run_test(int num, string name);
      int unsigned waited;
      test_checks = 0;
      test_fails  = 0;
      accepted    = 0;
      waited      = 0;
      while (accepted < NUM_TXN) begin
         step(1'b1);
      end
      // Drain and then idle a few cycles to catch duplicated results
      while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
         step(1'b0);
         waited++;
      end
      repeat (4) step(1'b0);
      test_checks++;
      if (exp_q.size() != 0) begin
         $display("%0d results never came out of the pipeline", exp_q.size());
         test_fails++;
         exp_q.delete();
         edge_q.delete();
      end
      pass_cnt += test_checks - test_fails;
      fail_cnt += test_fails;
      $display("test %0d %s done, %0d checks, %0d errors", num, name, test_checks,
               test_fails);
   endtask

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------

   initial begin
      rst       = 1'b1;
      a         = '0;
      b         = '0;
      op_sel    = 2'b00;
      in_valid  = 1'b0;
      out_ready = 1'b0;
      repeat (5) @(posedge clk);
      #2;
      rst = 1'b0;

      // Test 1 checks the idle outputs right after reset
      @(negedge clk);
      test_fails = 0;
      if (out_valid !== 1'b0) begin
         $display("CHECK FAILED out_valid expected %h actual %h", 1'b0, out_valid);
         test_fails++;
      end
      if (in_ready !== 1'b1) begin
         $display("CHECK FAILED in_ready expected %h actual %h", 1'b1, in_ready);
         test_fails++;
      end
      pass_cnt += 2 - test_fails;
      fail_cnt += test_fails;
      $display("test 1 reset_state done, 2 checks, %0d errors", test_fails);

      operand_mode  = MIX_RANDOM;
      op_mode       = OPS_MUL;
      ready_random  = 1'b0;
      check_latency = 1'b1;
      run_test(2, "mul_low_word");

      // Most negative times itself goes first
      force_a_q = '{32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff};
      force_b_q = '{32'h8000_0000, 32'h8000_0000, 32'h8000_0000};
      force_op_q = '{OP_MULH, OP_MULHSU, OP_MULH};
      operand_mode  = MIX_CORNER;
      op_mode       = OPS_HIGH_S;
      check_latency = 1'b0;
      run_test(3, "mulh_mulhsu_high_word");

      force_a_q = '{32'hffff_ffff};
      force_b_q = '{32'hffff_ffff};
      force_op_q = '{OP_MULHU};
      operand_mode = MIX_ONES;
      op_mode      = OPS_MULHU;
      run_test(4, "mulhu_high_word");

      operand_mode = MIX_CORNER;
      op_mode      = OPS_ANY;
      ready_random = 1'b1;
      run_test(5, "mixed_ops_backpressure");

      $display("checks %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule
